// File: verilog/intra4x4_pkg.sv
package intra4x4_pkg;

    localparam int FRAME_MBS_W = 4;                // Macroblocks per frame row
    localparam int FRAME_MBS_H = 4;                // Macroblocks per frame column
    localparam int FRAME_W     = FRAME_MBS_W * 16;
    localparam int FRAME_XW    = $clog2(FRAME_W);  // Top line buffer address width

    localparam int QP       = 27;
    localparam int QP_PER   = QP / 6;
    localparam int QP_REM   = QP % 6;
    localparam int Q_BITS   = 15 + QP_PER;
    localparam int Q_OFFSET = (1 << Q_BITS) / 3;   // Intra rounding

    // Multipliers and scales for QP_REM == 3
    localparam int MF_A = 9362;
    localparam int MF_B = 3647;
    localparam int MF_C = 5825;
    localparam int V_A  = 14;
    localparam int V_B  = 23;
    localparam int V_C  = 18;

    typedef logic [7:0]         pix_t;
    typedef logic signed [8:0]  res_t;
    typedef logic signed [14:0] coef_t;
    typedef logic [5:0]         mb_coord_t;
    typedef logic [3:0]         blk_idx_t;

    typedef struct packed {
        pix_t [15:0] p;     // p[0] is the leftmost pixel
    } mb_row_t;

    typedef struct packed {
        pix_t [15:0] p;     // Raster order, row * 4 + col
    } blk_pix_t;

    typedef struct packed {
        res_t [15:0] r;
    } blk_res_t;

    typedef struct packed {
        coef_t [15:0] c;
    } blk_coef_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       left_av;
        logic       top_av;
    } blk_pos_t;

    typedef enum logic [2:0] {IDLE, LOAD, PRED, FWD, INV, SAVE} ctrl_state_t;

    // Class A for even row and col, B for odd row and col, C otherwise
    function automatic logic [13:0] mf_of(input int idx);
        if (!idx[2] && !idx[0])
            return 14'(MF_A);
        else if (idx[2] && idx[0])
            return 14'(MF_B);
        return 14'(MF_C);
    endfunction

    function automatic logic [4:0] v_of(input int idx);
        if (!idx[2] && !idx[0])
            return 5'(V_A);
        else if (idx[2] && idx[0])
            return 5'(V_B);
        return 5'(V_C);
    endfunction

endpackage

// File: verilog/intra4x4_mb_buffer.sv
`timescale 1ns/1ps

module intra4x4_mb_buffer
    import intra4x4_pkg::*;
(
    input  logic       clk,
    input  logic       load_i,
    input  logic [3:0] row_sel_i,
    input  mb_row_t    row_i,
    input  blk_pos_t   pos_i,
    output blk_pix_t   src_o
);

    mb_row_t rows [16];

    always_ff @(posedge clk) begin
        if (load_i) begin
            rows[row_sel_i] <= row_i;
        end
    end

    // Block corners sit on multiples of four, so the window start is bits [3:2]
    always_comb begin
        logic [3:0] ry;
        logic [3:0] cx;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                ry = {pos_i.y[3:2], 2'(r)};
                cx = {pos_i.x[3:2], 2'(c)};
                src_o.p[r*4 + c] = rows[ry].p[cx];
            end
        end
    end

endmodule

// File: verilog/intra4x4_dc_pred.sv
`timescale 1ns/1ps

module intra4x4_dc_pred
    import intra4x4_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     pred_en_i,
    input  logic     save_en_i,
    input  blk_pos_t pos_i,
    input  blk_pix_t src_i,
    input  blk_pix_t recon_i,
    output blk_pix_t pred_o,
    output blk_res_t res_o
);

    pix_t top_buf  [FRAME_W];   // Bottom rows of the block line above
    pix_t left_col [16];        // Right columns, y within the macroblock

    logic [9:0]  sum_top;
    logic [9:0]  sum_left;
    logic [10:0] sum_both;
    pix_t        dc;
    blk_res_t    res_d;

    always_comb begin
        logic [FRAME_XW-1:0] tx;
        logic [3:0]          ly;
        sum_top  = '0;
        sum_left = '0;
        for (int k = 0; k < 4; k++) begin
            tx       = {pos_i.x[FRAME_XW-1:2], 2'(k)};
            ly       = {pos_i.y[3:2], 2'(k)};
            sum_top  = sum_top + 10'(top_buf[tx]);
            sum_left = sum_left + 10'(left_col[ly]);
        end
        sum_both = 11'(sum_top) + 11'(sum_left) + 11'd4;
        case ({pos_i.left_av, pos_i.top_av})
            2'b11:   dc = pix_t'(sum_both >> 3);
            2'b10:   dc = pix_t'((sum_left + 10'd2) >> 2);
            2'b01:   dc = pix_t'((sum_top + 10'd2) >> 2);
            default: dc = 8'd128;   // Frame corner
        endcase
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            res_d.r[i] = res_t'({1'b0, src_i.p[i]} - {1'b0, dc});
        end
    end

    always_ff @(posedge clk) begin
        if (pred_en_i) begin
            for (int i = 0; i < 16; i++) begin
                pred_o.p[i] <= dc;
            end
            res_o <= res_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FRAME_W; i++) begin
                top_buf[i] <= '0;
            end
            for (int j = 0; j < 16; j++) begin
                left_col[j] <= '0;
            end
        end else if (save_en_i) begin
            for (int k = 0; k < 4; k++) begin
                top_buf[{pos_i.x[FRAME_XW-1:2], 2'(k)}] <= recon_i.p[12 + k];  // Bottom row
                left_col[{pos_i.y[3:2], 2'(k)}]         <= recon_i.p[k*4 + 3]; // Right column
            end
        end
    end

endmodule

// File: verilog/intra4x4_fwd_tq.sv
`timescale 1ns/1ps

module intra4x4_fwd_tq
    import intra4x4_pkg::*;
(
    input  logic      clk,
    input  logic      fwd_en_i,
    input  blk_res_t  res_i,
    output blk_coef_t coef_o
);

    logic signed [15:0] h [16];     // After the row pass
    logic signed [15:0] w [16];     // After the column pass
    blk_coef_t          coef_d;

    function automatic void fwd_1d(
        input  logic signed [15:0] a0,
        input  logic signed [15:0] a1,
        input  logic signed [15:0] a2,
        input  logic signed [15:0] a3,
        output logic signed [15:0] y0,
        output logic signed [15:0] y1,
        output logic signed [15:0] y2,
        output logic signed [15:0] y3
    );
        logic signed [15:0] s0, s1, d0, d1;
        s0 = a0 + a3;
        s1 = a1 + a2;
        d0 = a0 - a3;
        d1 = a1 - a2;
        y0 = s0 + s1;
        y1 = (d0 <<< 1) + d1;
        y2 = s0 - s1;
        y3 = d0 - (d1 <<< 1);
    endfunction

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            fwd_1d($signed(res_i.r[4*r]), $signed(res_i.r[4*r + 1]),
                   $signed(res_i.r[4*r + 2]), $signed(res_i.r[4*r + 3]),
                   h[4*r], h[4*r + 1], h[4*r + 2], h[4*r + 3]);
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            fwd_1d(h[c], h[4 + c], h[8 + c], h[12 + c],
                   w[c], w[4 + c], w[8 + c], w[12 + c]);
        end
    end

    // Sign and magnitude quantisation with the intra offset
    always_comb begin
        logic [15:0] mag;
        logic [31:0] scaled;
        logic [15:0] lvl;
        for (int i = 0; i < 16; i++) begin
            mag         = w[i][15] ? 16'(-w[i]) : 16'(w[i]);
            scaled      = 32'(mag) * 32'(mf_of(i)) + 32'(Q_OFFSET);
            lvl         = 16'(scaled >> Q_BITS);
            coef_d.c[i] = w[i][15] ? coef_t'(-lvl) : coef_t'(lvl);
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_en_i) begin
            coef_o <= coef_d;
        end
    end

endmodule

// File: verilog/intra4x4_inv_tq.sv
`timescale 1ns/1ps

module intra4x4_inv_tq
    import intra4x4_pkg::*;
(
    input  logic      clk,
    input  logic      inv_en_i,
    input  blk_coef_t coef_i,
    input  blk_pix_t  pred_i,
    output blk_pix_t  recon_o
);

    logic signed [31:0] dq [16];    // Dequantised levels
    logic signed [31:0] g  [16];    // After the row pass
    logic signed [31:0] f  [16];    // After the column pass
    blk_pix_t           recon_d;

    function automatic void inv_1d(
        input  logic signed [31:0] a0,
        input  logic signed [31:0] a1,
        input  logic signed [31:0] a2,
        input  logic signed [31:0] a3,
        output logic signed [31:0] y0,
        output logic signed [31:0] y1,
        output logic signed [31:0] y2,
        output logic signed [31:0] y3
    );
        logic signed [31:0] e0, e1, e2, e3;
        e0 = a0 + a2;
        e1 = a0 - a2;
        e2 = (a1 >>> 1) - a3;   // Odd terms at half weight
        e3 = a1 + (a3 >>> 1);
        y0 = e0 + e3;
        y1 = e1 + e2;
        y2 = e1 - e2;
        y3 = e0 - e3;
    endfunction

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            dq[i] = ($signed(coef_i.c[i]) * $signed({1'b0, v_of(i)})) <<< QP_PER;
        end
    end

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            inv_1d(dq[4*r], dq[4*r + 1], dq[4*r + 2], dq[4*r + 3],
                   g[4*r], g[4*r + 1], g[4*r + 2], g[4*r + 3]);
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            inv_1d(g[c], g[4 + c], g[8 + c], g[12 + c],
                   f[c], f[4 + c], f[8 + c], f[12 + c]);
        end
    end

    always_comb begin
        logic signed [31:0] rs;
        logic signed [31:0] sum;
        for (int i = 0; i < 16; i++) begin
            rs  = (f[i] + 32'sd32) >>> 6;
            sum = rs + $signed({24'd0, pred_i.p[i]});
            if (sum < 0)
                recon_d.p[i] = 8'd0;
            else if (sum > 255)
                recon_d.p[i] = 8'd255;
            else
                recon_d.p[i] = sum[7:0];
        end
    end

    // Held through SAVE for the output and the neighbour store
    always_ff @(posedge clk) begin
        if (inv_en_i) begin
            recon_o <= recon_d;
        end
    end

endmodule

// File: verilog/intra4x4_ctrl.sv
`timescale 1ns/1ps

module intra4x4_ctrl
    import intra4x4_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       row_valid_i,
    input  mb_coord_t  mb_x_i,
    input  mb_coord_t  mb_y_i,
    output logic       row_ready_o,
    output logic       load_o,
    output logic [3:0] row_sel_o,
    output blk_pos_t   pos_o,
    output logic       pred_en_o,
    output logic       fwd_en_o,
    output logic       inv_en_o,
    output logic       save_en_o,
    output logic       blk_valid_o,
    output blk_idx_t   blk_idx_o
);

    ctrl_state_t state, state_nxt;
    logic [3:0]  row_cnt;
    blk_idx_t    blk_idx;
    mb_coord_t   mb_x, mb_y;
    logic        accept;

    assign row_ready_o = (state == IDLE) || (state == LOAD);
    assign accept      = row_valid_i && row_ready_o;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (accept) state_nxt = LOAD;
            LOAD: if (accept && row_cnt == 4'd15) state_nxt = PRED;
            PRED: state_nxt = FWD;
            FWD:  state_nxt = INV;
            INV:  state_nxt = SAVE;
            SAVE: state_nxt = (blk_idx == 4'd15) ? IDLE : PRED;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            row_cnt <= '0;
            blk_idx <= '0;
            mb_x    <= '0;
            mb_y    <= '0;
        end else begin
            state <= state_nxt;
            if (accept)
                row_cnt <= row_cnt + 4'd1;  // Wraps after the sixteenth row
            if (state == IDLE && accept) begin
                mb_x <= mb_x_i;
                mb_y <= mb_y_i;
            end
            if (state == SAVE)
                blk_idx <= blk_idx + 4'd1;
        end
    end

    // Z-scan: bits [3:2] pick the 8x8 quadrant, bits [1:0] the 4x4 block
    assign pos_o.x       = {mb_x, blk_idx[2], blk_idx[0], 2'b00};
    assign pos_o.y       = {mb_y, blk_idx[3], blk_idx[1], 2'b00};
    assign pos_o.left_av = (pos_o.x != 10'd0);
    assign pos_o.top_av  = (pos_o.y != 10'd0);

    assign load_o      = accept;
    assign row_sel_o   = row_cnt;
    assign pred_en_o   = (state == PRED);
    assign fwd_en_o    = (state == FWD);
    assign inv_en_o    = (state == INV);
    assign save_en_o   = (state == SAVE);
    assign blk_valid_o = (state == SAVE);
    assign blk_idx_o   = blk_idx;

endmodule

// File: verilog/intra4x4_top.sv
`timescale 1ns/1ps

module intra4x4_top
    import intra4x4_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      row_valid_i,
    input  mb_row_t   row_i,
    input  mb_coord_t mb_x_i,
    input  mb_coord_t mb_y_i,
    output logic      row_ready_o,
    output logic      blk_valid_o,
    output blk_idx_t  blk_idx_o,
    output blk_coef_t coef_o,
    output blk_pix_t  recon_o
);

    logic       load;
    logic [3:0] row_sel;
    blk_pos_t   pos;
    logic       pred_en, fwd_en, inv_en, save_en;
    blk_pix_t   src;
    blk_pix_t   pred;
    blk_res_t   res;

    intra4x4_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .row_valid_i (row_valid_i),
        .mb_x_i      (mb_x_i),
        .mb_y_i      (mb_y_i),
        .row_ready_o (row_ready_o),
        .load_o      (load),
        .row_sel_o   (row_sel),
        .pos_o       (pos),
        .pred_en_o   (pred_en),
        .fwd_en_o    (fwd_en),
        .inv_en_o    (inv_en),
        .save_en_o   (save_en),
        .blk_valid_o (blk_valid_o),
        .blk_idx_o   (blk_idx_o)
    );

    intra4x4_mb_buffer u_mb_buffer (
        .clk       (clk),
        .load_i    (load),
        .row_sel_i (row_sel),
        .row_i     (row_i),
        .pos_i     (pos),
        .src_o     (src)
    );

    intra4x4_dc_pred u_dc_pred (
        .clk       (clk),
        .rst       (rst),
        .pred_en_i (pred_en),
        .save_en_i (save_en),
        .pos_i     (pos),
        .src_i     (src),
        .recon_i   (recon_o),
        .pred_o    (pred),
        .res_o     (res)
    );

    intra4x4_fwd_tq u_fwd_tq (
        .clk      (clk),
        .fwd_en_i (fwd_en),
        .res_i    (res),
        .coef_o   (coef_o)
    );

    intra4x4_inv_tq u_inv_tq (
        .clk      (clk),
        .inv_en_i (inv_en),
        .coef_i   (coef_o),
        .pred_i   (pred),
        .recon_o  (recon_o)
    );

endmodule

// File: bench/intra4x4_top_tb.sv
`timescale 1ns/1ps

module intra4x4_top_tb
    import intra4x4_pkg::*;
();

    localparam int TIMEOUT_CYC = 2 * (16 * 4 + 16 * 4 + 20);

    logic      clk;
    logic      rst;
    logic      row_valid_i;
    mb_row_t   row_i;
    mb_coord_t mb_x_i;
    mb_coord_t mb_y_i;
    logic      row_ready_o;
    logic      blk_valid_o;
    blk_idx_t  blk_idx_o;
    blk_coef_t coef_o;
    blk_pix_t  recon_o;

    logic [127:0] row_mem [16];    // Source rows of the current macroblock
    logic [239:0] exp_coef [16];
    logic [127:0] exp_pix [16];
    logic [31:0]  rng = 32'h585d;
    int           cyc = 0;
    int           last_acc = 0;    // Cycle of the edge that took the last row

    intra4x4_top u_intra4x4_top (
        .clk         (clk),
        .rst         (rst),
        .row_valid_i (row_valid_i),
        .row_i       (row_i),
        .mb_x_i      (mb_x_i),
        .mb_y_i      (mb_y_i),
        .row_ready_o (row_ready_o),
        .blk_valid_o (blk_valid_o),
        .blk_idx_o   (blk_idx_o),
        .coef_o      (coef_o),
        .recon_o     (recon_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_run(input string msg);
        $display("%0s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_coef(input logic [8*16-1:0] name, input int b,
                              input blk_coef_t exp_v, input blk_coef_t act_v);
        if (act_v !== exp_v)
            stop_run($sformatf("MISMATCH %0s block %0d coef expected %h actual %h",
                               name, b, exp_v, act_v));
    endtask

    task automatic check_pix(input logic [8*16-1:0] name, input int b,
                             input blk_pix_t exp_v, input blk_pix_t act_v);
        if (act_v !== exp_v)
            stop_run($sformatf("MISMATCH %0s block %0d recon expected %h actual %h",
                               name, b, exp_v, act_v));
    endtask

    task automatic check_idx(input logic [8*16-1:0] name, input int b,
                             input blk_idx_t exp_v, input blk_idx_t act_v);
        if (act_v !== exp_v)
            stop_run($sformatf("MISMATCH %0s block %0d index expected %0d actual %0d",
                               name, b, exp_v, act_v));
    endtask

    task automatic check_cycle(input logic [8*16-1:0] name, input int b,
                               input int exp_v, input int act_v);
        if (act_v != exp_v)
            stop_run($sformatf("MISMATCH %0s block %0d cycle expected %0d actual %0d",
                               name, b, exp_v, act_v));
    endtask

    // One beat per row, random idle cycles in front of each
    task automatic send_rows(input int mbx, input int mby);
        int   gap;
        logic ready;
        @(posedge clk);
        for (int r = 0; r < 16; r++) begin
            rng = next_rand(rng);
            gap = int'(rng[1:0]);
            repeat (gap) begin
                row_valid_i <= 1'b0;
                @(posedge clk);
            end
            row_valid_i <= 1'b1;
            row_i       <= row_mem[r];
            mb_x_i      <= mb_coord_t'(mbx);
            mb_y_i      <= mb_coord_t'(mby);
            ready = 1'b0;
            while (!ready) begin
                @(negedge clk);
                ready = row_ready_o;
                if (ready)
                    last_acc = cyc + 1;
                @(posedge clk);
            end
        end
        row_valid_i <= 1'b0;
    endtask

    // Optionally offers junk beats while the blocks are processed
    task automatic collect_blocks(input logic [8*16-1:0] name, input logic offer);
        int b;
        int prev;
        b    = 0;
        prev = 0;
        while (b < 16) begin
            @(posedge clk);
            if (offer) begin
                row_valid_i <= (b >= 1 && b <= 12);
                row_i       <= {16{8'haa}};
            end
            @(negedge clk);
            if (row_ready_o)
                stop_run("row_ready_o was high while blocks were being processed");
            if (blk_valid_o) begin
                if (b == 0)
                    check_cycle(name, b, last_acc + 3, cyc);
                else
                    check_cycle(name, b, prev + 4, cyc);
                prev = cyc;
                check_idx(name, b, blk_idx_t'(b), blk_idx_o);
                check_coef(name, b, exp_coef[b], coef_o);
                check_pix(name, b, exp_pix[b], recon_o);
                b++;
            end
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC)
            stop_run("Timeout: the DUT produced no block output in time");
    end

    initial begin
        int                 fd;
        int                 n;
        int                 mbx;
        int                 mby;
        int                 idx_rd;
        logic [8*128-1:0]   hdr_line;
        logic [8*16-1:0]    test_name;
        rst         = 1'b1;
        row_valid_i = 1'b0;
        row_i       = '0;
        mb_x_i      = '0;
        mb_y_i      = '0;
        fd = $fopen("bench/intra4x4_golden.txt", "r");
        if (fd == 0)
            stop_run("Could not open bench/intra4x4_golden.txt");
        n = $fgets(hdr_line, fd);
        n = $fgets(hdr_line, fd);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (row_ready_o !== 1'b1 || blk_valid_o !== 1'b0)
            stop_run("After reset row_ready_o is not high or blk_valid_o is not low");
        for (int mb = 0; mb < 2; mb++) begin
            n = $fscanf(fd, " %s %d %d", test_name, mbx, mby);
            if (n != 3)
                stop_run("Golden file has a bad test name line");
            for (int i = 0; i < 16; i++) begin
                n = $fscanf(fd, " %h", row_mem[i]);
                if (n != 1)
                    stop_run("Golden file has a bad row line");
            end
            for (int i = 0; i < 16; i++) begin
                n = $fscanf(fd, " %d %h %h", idx_rd, exp_coef[i], exp_pix[i]);
                if (n != 3 || idx_rd != i)
                    stop_run("Golden file has a bad expected block line");
            end
            send_rows(mbx, mby);
            collect_blocks(test_name, mb == 0);
        end
        $fclose(fd);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: bench/intra4x4_golden.txt
// Per macroblock: name mb_x mb_y, then 16 source rows (hex, pixel 0 in the low byte),
// then 16 lines of block index, coefficients (hex, c[0] low) and reconstruction (hex)
mb_0_0 0 0
5a5a5a5a646464648c8c8c8c80808080
5a5a5a5a646464648c8c8c8c80808080
5a5a5a5a646464648c8c8c8c80808080
5a5a5a5a646464648c8c8c8c80808080
5f5f5f5f6e6e6e6e8787878778787878
5f5f5f5f6e6e6e6e8787878778787878
5f5f5f5f6e6e6e6e8787878778787878
5f5f5f5f6e6e6e6e8787878778787878
3c3c3c3c7d7d7d7d8282828296969696
3c3c3c3c7d7d7d7d8282828296969696
3c3c3c3c7d7d7d7d8282828296969696
3c3c3c3c7d7d7d7d8282828296969696
323232328c8c8c8caaaaaaaac8c8c8c8
323232328c8c8c8caaaaaaaac8c8c8c8
323232328c8c8c8caaaaaaaac8c8c8c8
323232328c8c8c8caaaaaaaac8c8c8c8
0 000000000000000000000000000000000000000000000000000000000000 80808080808080808080808080808080
1 000000000000000000000000000000000000000000000000000000000003 8b8b8b8b8b8b8b8b8b8b8b8b8b8b8b8b
2 000000000000000000000000000000000000000000000000000000007ffe 79797979797979797979797979797979
3 000000000000000000000000000000000000000000000000000000000001 86868686868686868686868686868686
4 000000000000000000000000000000000000000000000000000000007ff5 65656565656565656565656565656565
5 000000000000000000000000000000000000000000000000000000007ffd 5b5b5b5b5b5b5b5b5b5b5b5b5b5b5b5b
6 000000000000000000000000000000000000000000000000000000007ffe 6f6f6f6f6f6f6f6f6f6f6f6f6f6f6f6f
7 000000000000000000000000000000000000000000000000000000007ffe 5e5e5e5e5e5e5e5e5e5e5e5e5e5e5e5e
8 000000000000000000000000000000000000000000000000000000000008 95959595959595959595959595959595
9 000000000000000000000000000000000000000000000000000000007ffd 84848484848484848484848484848484
10 00000000000000000000000000000000000000000000000000000000000e c6c6c6c6c6c6c6c6c6c6c6c6c6c6c6c6
11 000000000000000000000000000000000000000000000000000000000001 a9a9a9a9a9a9a9a9a9a9a9a9a9a9a9a9
12 000000000000000000000000000000000000000000000000000000000001 7e7e7e7e7e7e7e7e7e7e7e7e7e7e7e7e
13 000000000000000000000000000000000000000000000000000000007ff2 3d3d3d3d3d3d3d3d3d3d3d3d3d3d3d3d
14 000000000000000000000000000000000000000000000000000000007ffe 8d8d8d8d8d8d8d8d8d8d8d8d8d8d8d8d
15 000000000000000000000000000000000000000000000000000000007ff2 34343434343434343434343434343434
mb_1_0 1 0
00000000ffffffffc8c8c8c83c3c3c3c
00000000ffffffffc8c8c8c83c3c3c3c
00000000ffffffffc8c8c8c83c3c3c3c
00000000ffffffffc8c8c8c83c3c3c3c
0a0a0a0af0f0f0f0b4b4b4b45a5a5a5a
0a0a0a0af0f0f0f0b4b4b4b45a5a5a5a
0a0a0a0af0f0f0f0b4b4b4b45a5a5a5a
0a0a0a0af0f0f0f0b4b4b4b45a5a5a5a
64646464646464646464646464646464
64646464646464646464646464646464
64646464646464646464646464646464
64646464646464646464646464646464
80808080dcdcdcdc464646461e1e1e1e
80808080dcdcdcdc464646461e1e1e1e
80808080dcdcdcdc464646461e1e1e1e
80808080dcdcdcdc464646461e1e1e1e
0 000000000000000000000000000000000000000000000000000000007ff7 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
1 000000000000000000000000000000000000000000000000000000000028 c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8
2 000000000000000000000000000000000000000000000000000000000004 5b5b5b5b5b5b5b5b5b5b5b5b5b5b5b5b
3 00000000000000000000000000000000000000000000000000000000000a b5b5b5b5b5b5b5b5b5b5b5b5b5b5b5b5
4 000000000000000000000000000000000000000000000000000000000010 ffffffffffffffffffffffffffffffff
5 000000000000000000000000000000000000000000000000000000007fb7 00000000000000000000000000000000
6 000000000000000000000000000000000000000000000000000000000006 efefefefefefefefefefefefefefefef
7 000000000000000000000000000000000000000000000000000000007fe1 0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c
8 000000000000000000000000000000000000000000000000000000000007 65656565656565656565656565656565
9 000000000000000000000000000000000000000000000000000000007ff4 63636363636363636363636363636363
10 000000000000000000000000000000000000000000000000000000007ff3 20202020202020202020202020202020
11 000000000000000000000000000000000000000000000000000000000001 46464646464646464646464646464646
12 000000000000000000000000000000000000000000000000000000007fec 63636363636363636363636363636363
13 00000000000000000000000000000000000000000000000000000000000c 62626262626262626262626262626262
14 000000000000000000000000000000000000000000000000000000000026 dadadadadadadadadadadadadadadada
15 000000000000000000000000000000000000000000000000000000007ff8 82828282828282828282828282828282

// File: intra4x4_top.f
verilog/intra4x4_pkg.sv
verilog/intra4x4_mb_buffer.sv
verilog/intra4x4_dc_pred.sv
verilog/intra4x4_fwd_tq.sv
verilog/intra4x4_inv_tq.sv
verilog/intra4x4_ctrl.sv
verilog/intra4x4_top.sv
bench/intra4x4_top_tb.sv
